//--- source/renamePkg.sv
package renamePkg;

    // group shape
    localparam int NumWays = 4;
    localparam int NumSrcs = 2;

    // register files
    localparam int NumArchRegs = 32;
    localparam int NumPhysRegs = 128;
    localparam int ArchIdxW = $clog2(NumArchRegs);
    localparam int PhysIdxW = $clog2(NumPhysRegs);

    typedef logic [ArchIdxW-1:0] archIdx_t;
    typedef logic [PhysIdxW-1:0] physIdx_t;

    // one source operand as decoded
    typedef struct packed {
        logic     valid;
        archIdx_t arch;
    } archSrc_t;

    // decoded operation, dstPhys comes from the free list
    typedef struct packed {
        archSrc_t [NumSrcs-1:0] src;
        logic                   dstValid;
        archIdx_t               dstArch;
        physIdx_t               dstPhys;
    } archOp_t;

    // one source operand after renaming
    typedef struct packed {
        logic     valid;
        logic     notProduced;
        physIdx_t phys;
    } physSrc_t;

    // renamed operation
    // prevPhys is the mapping the destination replaces, freed at retire
    typedef struct packed {
        physSrc_t [NumSrcs-1:0] src;
        logic                   dstValid;
        physIdx_t               dstPhys;
        physIdx_t               prevPhys;
    } renamedOp_t;

endpackage

//--- source/mapTable.sv
`timescale 1ns/100ps

module mapTable import renamePkg::*; (
    input  logic     Clk,
    input  logic     arstN,
    input  logic     flush,
    input  logic     writeEn,
    input  archIdx_t srcArch [NumWays][NumSrcs],
    input  logic     dstValid [NumWays],
    input  archIdx_t dstArch [NumWays],
    input  physIdx_t dstPhys [NumWays],
    output physIdx_t srcMap [NumWays][NumSrcs],
    output physIdx_t dstMap [NumWays]
);

    // arch -> phys map, one entry per architectural register
    physIdx_t mapReg [NumArchRegs];

    // identity on reset and flush, flush wins over a pending write
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumArchRegs; i++) begin
                mapReg[i] <= physIdx_t'(i);
            end
        end else if (flush) begin
            for (int i = 0; i < NumArchRegs; i++) begin
                mapReg[i] <= physIdx_t'(i);
            end
        end else if (writeEn) begin
            // oldest way first, the last nonblocking write to an entry sticks
            for (int w = 0; w < NumWays; w++) begin
                if (dstValid[w]) begin
                    mapReg[dstArch[w]] <= dstPhys[w];
                end
            end
        end
    end

    // source read ports
    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            for (int s = 0; s < NumSrcs; s++) begin
                srcMap[w][s] = mapReg[srcArch[w][s]];
            end
        end
    end

    // destination read ports, give the mapping being replaced
    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            dstMap[w] = mapReg[dstArch[w]];
        end
    end

endmodule

//--- source/intraGroupBypass.sv
`timescale 1ns/100ps

module intraGroupBypass import renamePkg::*; (
    input  archOp_t    group [NumWays],
    input  physIdx_t   srcMap [NumWays][NumSrcs],
    input  physIdx_t   dstMap [NumWays],
    output renamedOp_t renamed [NumWays]
);

    // Resolve one architectural index for the given way. Older ways of the
    // group that write the same register override the table value; the scan
    // runs upward so the youngest of them is the one that remains.
    function automatic physSrc_t resolve(
        input archOp_t     ops [NumWays],
        input int unsigned way,
        input archIdx_t    arch,
        input physIdx_t    tableMap
    );
        physSrc_t res;

        res.valid       = 1'b1;
        res.notProduced = 1'b0;
        res.phys        = tableMap;
        for (int unsigned j = 0; j < NumWays; j++) begin
            if (j < way && ops[j].dstValid && ops[j].dstArch == arch) begin
                res.notProduced = 1'b1;
                res.phys        = ops[j].dstPhys;
            end
        end
        return res;
    endfunction

    always_comb begin
        physSrc_t prevRes;

        for (int unsigned k = 0; k < NumWays; k++) begin
            // sources
            for (int s = 0; s < NumSrcs; s++) begin
                if (group[k].src[s].valid) begin
                    renamed[k].src[s] = resolve(group, k, group[k].src[s].arch, srcMap[k][s]);
                end else begin
                    renamed[k].src[s] = '0;
                end
            end

            // destination and the mapping it replaces
            renamed[k].dstValid = group[k].dstValid;
            prevRes             = resolve(group, k, group[k].dstArch, dstMap[k]);
            if (group[k].dstValid) begin
                renamed[k].dstPhys  = group[k].dstPhys;
                renamed[k].prevPhys = prevRes.phys;
            end else begin
                renamed[k].dstPhys  = '0;
                renamed[k].prevPhys = '0;
            end
        end
    end

endmodule

//--- source/renameOutReg.sv
`timescale 1ns/100ps

module renameOutReg import renamePkg::*; (
    input  logic       Clk,
    input  logic       arstN,
    input  logic       stall,
    input  logic       flush,
    input  renamedOp_t nextGroup [NumWays],
    output renamedOp_t group [NumWays]
);

    // a stalled or flushed cycle leaves a bubble group behind
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int w = 0; w < NumWays; w++) begin
                group[w] <= '0;
            end
        end else if (flush || stall) begin
            for (int w = 0; w < NumWays; w++) begin
                group[w] <= '0;
            end
        end else begin
            for (int w = 0; w < NumWays; w++) begin
                group[w] <= nextGroup[w];
            end
        end
    end

endmodule

//--- source/renameStage.sv
`timescale 1ns/100ps

module renameStage import renamePkg::*; (
    input  logic       Clk,
    input  logic       arstN,
    input  logic       stall,
    input  logic       flush,
    input  archOp_t    inGroup [NumWays],
    output renamedOp_t outGroup [NumWays]
);

    logic       writeEn;
    archIdx_t   srcArch [NumWays][NumSrcs];
    logic       dstValid [NumWays];
    archIdx_t   dstArch [NumWays];
    physIdx_t   dstPhys [NumWays];
    physIdx_t   srcMap [NumWays][NumSrcs];
    physIdx_t   dstMap [NumWays];
    renamedOp_t renamedNext [NumWays];

    // table only moves on a live, unflushed cycle
    assign writeEn = ~stall & ~flush;

    // split the group into table lookup and write fields
    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            for (int s = 0; s < NumSrcs; s++) begin
                srcArch[w][s] = inGroup[w].src[s].arch;
            end
            dstValid[w] = inGroup[w].dstValid;
            dstArch[w]  = inGroup[w].dstArch;
            dstPhys[w]  = inGroup[w].dstPhys;
        end
    end

    mapTable mapTable0 (
        .Clk      (Clk),
        .arstN    (arstN),
        .flush    (flush),
        .writeEn  (writeEn),
        .srcArch  (srcArch),
        .dstValid (dstValid),
        .dstArch  (dstArch),
        .dstPhys  (dstPhys),
        .srcMap   (srcMap),
        .dstMap   (dstMap)
    );

    intraGroupBypass bypass0 (
        .group   (inGroup),
        .srcMap  (srcMap),
        .dstMap  (dstMap),
        .renamed (renamedNext)
    );

    renameOutReg outReg0 (
        .Clk       (Clk),
        .arstN     (arstN),
        .stall     (stall),
        .flush     (flush),
        .nextGroup (renamedNext),
        .group     (outGroup)
    );

endmodule

//--- verification/renameModel.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// whole groups as packed vectors, way 0 in the low slot
typedef archOp_t    [NumWays-1:0] opGroup_t;
typedef renamedOp_t [NumWays-1:0] renamedGroup_t;

// expected arch -> phys map
physIdx_t modelMap [NumArchRegs];

// identity map, as after reset or flush
task automatic resetModel();
    for (int i = 0; i < NumArchRegs; i++) begin
        modelMap[i] = physIdx_t'(i);
    end
endtask

// group commit, later ways overwrite earlier ones
task automatic commitModel(input opGroup_t ops);
    for (int w = 0; w < NumWays; w++) begin
        if (ops[w].dstValid) begin
            modelMap[ops[w].dstArch] = ops[w].dstPhys;
        end
    end
endtask

// latest older way writing arch wins, else the map
function automatic physSrc_t lookupArch(input opGroup_t ops, input int way,
                                        input archIdx_t arch);
    physSrc_t res;

    res.valid       = 1'b1;
    res.notProduced = 1'b0;
    res.phys        = modelMap[arch];
    for (int j = way - 1; j >= 0; j--) begin
        if (ops[j].dstValid && ops[j].dstArch == arch) begin
            res.notProduced = 1'b1;
            res.phys        = ops[j].dstPhys;
            return res;
        end
    end
    return res;
endfunction

// expected renamed group for a live cycle
function automatic renamedGroup_t expectGroup(input opGroup_t ops);
    renamedGroup_t exp;
    physSrc_t      prev;

    exp = '0;
    for (int k = 0; k < NumWays; k++) begin
        for (int s = 0; s < NumSrcs; s++) begin
            if (ops[k].src[s].valid) begin
                exp[k].src[s] = lookupArch(ops, k, ops[k].src[s].arch);
            end
        end
        if (ops[k].dstValid) begin
            prev            = lookupArch(ops, k, ops[k].dstArch);
            exp[k].dstValid = 1'b1;
            exp[k].dstPhys  = ops[k].dstPhys;
            exp[k].prevPhys = prev.phys;
        end
    end
    return exp;
endfunction

`endif

//--- verification/tbRenameStage.sv
`timescale 1ns/100ps

module tbRenameStage import renamePkg::*; ();

`include "renameModel.svh"

    logic       Clk;
    logic       arstN;
    logic       stall;
    logic       flush;
    archOp_t    inGroup [NumWays];
    renamedOp_t outGroup [NumWays];

    renamedGroup_t expQ [$];
    integer        seed;
    physIdx_t      nextPhys;
    int            pushedCount;
    int            checkedCount;

    renameStage dut0 (
        .Clk      (Clk),
        .arstN    (arstN),
        .stall    (stall),
        .flush    (flush),
        .inGroup  (inGroup),
        .outGroup (outGroup)
    );

    initial begin
        Clk = 1'b0;
        forever begin
            #50 Clk = ~Clk;
        end
    end

    task automatic failRun();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic checkField(input int way, input string field, input int got, input int want);
        assert (got == want) else begin
            $display("FAILED at %0t ns: way %0d %s is %0h, expected %0h",
                     $time, way, field, got, want);
            failRun();
        end
    endtask

    task automatic checkGroup(input renamedGroup_t exp);
        for (int w = 0; w < NumWays; w++) begin
            for (int s = 0; s < NumSrcs; s++) begin
                checkField(w, $sformatf("src%0d valid", s),
                           int'(outGroup[w].src[s].valid), int'(exp[w].src[s].valid));
                checkField(w, $sformatf("src%0d notProduced", s),
                           int'(outGroup[w].src[s].notProduced),
                           int'(exp[w].src[s].notProduced));
                checkField(w, $sformatf("src%0d phys", s),
                           int'(outGroup[w].src[s].phys), int'(exp[w].src[s].phys));
            end
            checkField(w, "dstValid", int'(outGroup[w].dstValid), int'(exp[w].dstValid));
            checkField(w, "dstPhys", int'(outGroup[w].dstPhys), int'(exp[w].dstPhys));
            checkField(w, "prevPhys", int'(outGroup[w].prevPhys), int'(exp[w].prevPhys));
        end
    endtask

    // stand-in free list cycling through the non-identity registers
    function automatic physIdx_t allocPhys();
        physIdx_t p;

        p = nextPhys;
        if (nextPhys == physIdx_t'(NumPhysRegs - 1)) begin
            nextPhys = physIdx_t'(NumArchRegs);
        end else begin
            nextPhys = nextPhys + 1'b1;
        end
        return p;
    endfunction

    function automatic archOp_t makeOp(input bit s0Valid, input int s0, input bit s1Valid,
                                       input int s1, input bit dValid, input int d);
        archOp_t op;

        op.src[0].valid = s0Valid;
        op.src[0].arch  = archIdx_t'(s0);
        op.src[1].valid = s1Valid;
        op.src[1].arch  = archIdx_t'(s1);
        op.dstValid     = dValid;
        op.dstArch      = archIdx_t'(d);
        op.dstPhys      = dValid ? allocPhys() : '0;
        return op;
    endfunction

    // narrow index range half the time to force collisions
    function automatic archOp_t randomOp();
        logic [31:0] r;
        archIdx_t    mask;

        r    = $random(seed);
        mask = r[31] ? archIdx_t'(7) : archIdx_t'(31);
        return makeOp(r[0], int'(r[5:1] & mask), r[6], int'(r[11:7] & mask),
                      r[12], int'(r[17:13] & mask));
    endfunction

    task automatic driveGroup(input opGroup_t g, input bit stallV, input bit flushV);
        renamedGroup_t exp;

        @(negedge Clk);
        for (int w = 0; w < NumWays; w++) begin
            inGroup[w] = g[w];
        end
        stall = stallV;
        flush = flushV;
        if (stallV || flushV) begin
            exp = '0;
        end else begin
            exp = expectGroup(g);
        end
        expQ.push_back(exp);
        pushedCount++;
        if (flushV) begin
            resetModel();
        end else if (!stallV) begin
            commitModel(g);
        end
    endtask

    task automatic waitChecked(input int limit);
        int cycles;

        cycles = 0;
        while (checkedCount != pushedCount) begin
            if (cycles == limit) begin
                $display("timeout: only %0d of %0d groups were compared",
                         checkedCount, pushedCount);
                failRun();
            end
            @(negedge Clk);
            cycles++;
        end
    endtask

    // compare one cycle behind the stimulus
    initial begin : compareProc
        renamedGroup_t expGroup;
        bit            haveExp;

        forever begin
            @(posedge Clk);
            haveExp = (expQ.size() != 0);
            if (haveExp) begin
                expGroup = expQ.pop_front();
            end
            @(negedge Clk);
            if (haveExp) begin
                checkGroup(expGroup);
                checkedCount++;
            end
        end
    end

    initial begin : stimulus
        opGroup_t g;
        logic [31:0] r;

        seed         = 32'hbe69_1ecf;
        nextPhys     = physIdx_t'(NumArchRegs);
        pushedCount  = 0;
        checkedCount = 0;
        arstN        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            inGroup[w] = '0;
        end
        resetModel();
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;
        checkGroup('0);

        // identity reads
        for (int w = 0; w < NumWays; w++) begin
            g[w] = makeOp(1'b1, w * 8, 1'b1, w * 8 + 3, 1'b0, 0);
        end
        driveGroup(g, 1'b0, 1'b0);

        // writes seen by the next group
        for (int w = 0; w < NumWays; w++) begin
            g[w] = makeOp(1'b0, 0, 1'b0, 0, 1'b1, w + 1);
        end
        driveGroup(g, 1'b0, 1'b0);
        for (int w = 0; w < NumWays; w++) begin
            g[w] = makeOp(1'b1, w + 1, 1'b1, 4 - w, 1'b1, w + 1);
        end
        driveGroup(g, 1'b0, 1'b0);

        // chain on r5 inside one group
        g[0] = makeOp(1'b0, 0, 1'b0, 0, 1'b1, 5);
        g[1] = makeOp(1'b1, 5, 1'b1, 6, 1'b1, 5);
        g[2] = makeOp(1'b1, 5, 1'b0, 0, 1'b0, 0);
        g[3] = makeOp(1'b0, 0, 1'b1, 5, 1'b1, 5);
        driveGroup(g, 1'b0, 1'b0);

        // two writers of r7 where the younger must stick
        g[0] = makeOp(1'b0, 0, 1'b0, 0, 1'b0, 0);
        g[1] = makeOp(1'b0, 0, 1'b0, 0, 1'b1, 7);
        g[2] = makeOp(1'b0, 0, 1'b0, 0, 1'b0, 0);
        g[3] = makeOp(1'b0, 0, 1'b0, 0, 1'b1, 7);
        driveGroup(g, 1'b0, 1'b0);
        g    = '0;
        g[0] = makeOp(1'b1, 7, 1'b1, 5, 1'b0, 0);
        driveGroup(g, 1'b0, 1'b0);

        // stalled writes must not land
        g    = '0;
        g[0] = makeOp(1'b1, 9, 1'b0, 0, 1'b1, 9);
        g[2] = makeOp(1'b0, 0, 1'b1, 10, 1'b1, 10);
        driveGroup(g, 1'b1, 1'b0);
        g    = '0;
        g[0] = makeOp(1'b1, 9, 1'b1, 10, 1'b1, 9);
        driveGroup(g, 1'b0, 1'b0);

        // flush then back to identity
        for (int w = 0; w < NumWays; w++) begin
            g[w] = makeOp(1'b1, w, 1'b0, 0, 1'b1, w + 12);
        end
        driveGroup(g, 1'b0, 1'b1);
        for (int w = 0; w < NumWays; w++) begin
            g[w] = makeOp(1'b1, w + 1, 1'b1, w + 5, 1'b1, w + 9);
        end
        driveGroup(g, 1'b0, 1'b0);
        waitChecked(10);

        // long random run
        for (int n = 0; n < 400; n++) begin
            for (int w = 0; w < NumWays; w++) begin
                g[w] = randomOp();
            end
            r = $random(seed);
            driveGroup(g, r[2:0] == 3'd0, r[8:4] == 5'd0);
        end
        driveGroup('0, 1'b0, 1'b0);
        waitChecked(10);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- src.f
+incdir+verification
source/renamePkg.sv
source/mapTable.sv
source/intraGroupBypass.sv
source/renameOutReg.sv
source/renameStage.sv
verification/tbRenameStage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tbRenameStage
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

# the log decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
